// File: cpuPkg.sv
package cpuPkg;

    parameter int dataWidth = 32;
    parameter int regAddrWidth = 5;

    // Major opcodes, instruction bits 31:27
    localparam logic [4:0] opRType = 5'b00000;
    localparam logic [4:0] opJ     = 5'b00001;
    localparam logic [4:0] opBne   = 5'b00010;
    localparam logic [4:0] opJal   = 5'b00011;
    localparam logic [4:0] opJr    = 5'b00100;
    localparam logic [4:0] opAddi  = 5'b00101;
    localparam logic [4:0] opBlt   = 5'b00110;
    localparam logic [4:0] opSw    = 5'b00111;
    localparam logic [4:0] opLw    = 5'b01000;

    // R-type function field
    localparam logic [4:0] aluAdd = 5'd0;
    localparam logic [4:0] aluSub = 5'd1;
    localparam logic [4:0] aluAnd = 5'd2;
    localparam logic [4:0] aluOr  = 5'd3;
    localparam logic [4:0] aluSll = 5'd4;
    localparam logic [4:0] aluSra = 5'd5;

    localparam logic [regAddrWidth-1:0] linkReg = 5'd31; // jal destination

    typedef struct packed {
        logic [4:0] opcode;
        logic [regAddrWidth-1:0] rd;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [4:0] shamt;
        logic [4:0] aluOp;
        logic [1:0] spare;
    } rFmtT;

    typedef struct packed {
        logic [4:0] opcode;
        logic [regAddrWidth-1:0] rd;
        logic [regAddrWidth-1:0] rs;
        logic [16:0] imm;
    } iFmtT;

    typedef struct packed {
        logic [4:0] opcode;
        logic [26:0] target;
    } jFmtT;

    // Three views of one word
    typedef union packed {
        rFmtT rFmt;
        iFmtT iFmt;
        jFmtT jFmt;
    } instrU;

    localparam instrU nopWord = '0; // add r0, r0, r0

    typedef struct packed {
        logic taken;
        logic [dataWidth-1:0] target;
    } redirectT;

    typedef struct packed {
        logic en;
        logic [regAddrWidth-1:0] addr;
        logic [dataWidth-1:0] data;
    } wbReqT;

    // Producer info for bypassing
    typedef struct packed {
        logic [regAddrWidth-1:0] dest;
        logic writesReg;
        logic isLoad;
        logic [dataWidth-1:0] value; // ALU result or load address
    } stageTagT;

    // Second read port takes rd for these and rt otherwise
    function automatic logic [regAddrWidth-1:0] portBReg(instrU ins);
        case (ins.rFmt.opcode)
            opSw, opBne, opBlt, opJr: return ins.rFmt.rd;
            default: return ins.rFmt.rt;
        endcase
    endfunction

endpackage

// File: aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    input  logic [cpuPkg::dataWidth-1:0] a,
    input  logic [cpuPkg::dataWidth-1:0] b,
    input  logic [4:0] aluOp,
    input  logic [4:0] shamt,
    output logic [cpuPkg::dataWidth-1:0] result,
    output logic notEqual,
    output logic lessThan
);

    always_comb begin
        case (aluOp)
            cpuPkg::aluAdd: result = a + b;
            cpuPkg::aluSub: result = a - b;
            cpuPkg::aluAnd: result = a & b;
            cpuPkg::aluOr:  result = a | b;
            cpuPkg::aluSll: result = a << shamt;
            cpuPkg::aluSra: result = $signed(a) >>> shamt; // Sign fill
            default:        result = a + b;
        endcase
    end

    assign notEqual = a != b;
    assign lessThan = $signed(a) < $signed(b);

endmodule

// File: bypassUnit.sv
`timescale 1ns/1ps

module bypassUnit (
    input  cpuPkg::instrU decodeIns,
    input  logic [cpuPkg::dataWidth-1:0] opA,
    input  logic [cpuPkg::dataWidth-1:0] opB,
    input  cpuPkg::stageTagT exTag,
    input  cpuPkg::wbReqT wb,
    input  logic [cpuPkg::dataWidth-1:0] dmemQ,
    output logic [cpuPkg::dataWidth-1:0] aluA,
    output logic [cpuPkg::dataWidth-1:0] aluB,
    output logic [cpuPkg::dataWidth-1:0] storeData
);
    logic [cpuPkg::regAddrWidth-1:0] srcB;

    // Newest producer wins
    function automatic logic [cpuPkg::dataWidth-1:0] pick(
        input logic [cpuPkg::regAddrWidth-1:0] src,
        input logic [cpuPkg::dataWidth-1:0] rfVal,
        input logic takeLoad
    );
        if (src != '0 && exTag.writesReg && exTag.dest == src) begin
            if (!exTag.isLoad)
                return exTag.value;
            return takeLoad ? dmemQ : rfVal; // Live load data
        end
        if (src != '0 && wb.en && wb.addr == src)
            return wb.data;
        return rfVal;
    endfunction

    assign srcB = cpuPkg::portBReg(decodeIns);

    always_comb begin
        aluA = pick(decodeIns.rFmt.rs, opA, 1'b1);
        aluB = pick(srcB, opB, 1'b1);
        // Load one ahead of a store is patched in the memory stage instead
        storeData = pick(srcB, opB, 1'b0);
    end

endmodule

// File: regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic clock,
    input  logic rstN,
    input  logic [cpuPkg::regAddrWidth-1:0] readRegA,
    input  logic [cpuPkg::regAddrWidth-1:0] readRegB,
    input  cpuPkg::wbReqT wb,
    output logic [cpuPkg::dataWidth-1:0] readDataA,
    output logic [cpuPkg::dataWidth-1:0] readDataB
);
    logic [cpuPkg::dataWidth-1:0] regs [0:31];

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.addr != '0) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // Write-through so a same-cycle write is seen by the reader
    assign readDataA = (readRegA == '0) ? '0 :
                       (wb.en && wb.addr == readRegA) ? wb.data : regs[readRegA];
    assign readDataB = (readRegB == '0) ? '0 :
                       (wb.en && wb.addr == readRegB) ? wb.data : regs[readRegB];

    zeroReg: assert property (@(posedge clock) disable iff (!rstN)
        (readRegA != '0 || readDataA == '0) && (readRegB != '0 || readDataB == '0));

endmodule

// File: fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit #(
    parameter int pcBits = 32
) (
    input  logic clock,
    input  logic rstN,
    input  logic [cpuPkg::dataWidth-1:0] imemData,
    input  cpuPkg::redirectT redirect,
    output logic [cpuPkg::dataWidth-1:0] imemAddress,
    output cpuPkg::instrU fetchIns,
    output logic [pcBits-1:0] fetchPc,
    output cpuPkg::instrU decodeIns,
    output logic [pcBits-1:0] decodePc
);
    logic [pcBits-1:0] pc;

    always_comb begin
        imemAddress = '0;
        imemAddress[pcBits-1:0] = pc; // Zero-extended
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
            fetchIns <= cpuPkg::nopWord;
            fetchPc <= '0;
            decodeIns <= cpuPkg::nopWord;
            decodePc <= '0;
        end else begin
            pc <= redirect.taken ? redirect.target[pcBits-1:0] : pc + 1'b1; // Wraps
            fetchPc <= pc;
            decodePc <= fetchPc;
            // Taken transfer squashes both younger slots
            fetchIns <= redirect.taken ? cpuPkg::nopWord : cpuPkg::instrU'(imemData);
            decodeIns <= redirect.taken ? cpuPkg::nopWord : fetchIns;
        end
    end

    flushedSlot: assert property (@(posedge clock) disable iff (!rstN)
        redirect.taken |=> decodeIns == cpuPkg::nopWord);

endmodule

// File: decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic clock,
    input  logic rstN,
    input  cpuPkg::instrU fetchIns,
    input  cpuPkg::wbReqT wb,
    output logic [cpuPkg::dataWidth-1:0] opA,
    output logic [cpuPkg::dataWidth-1:0] opB
);
    logic [cpuPkg::regAddrWidth-1:0] readRegA;
    logic [cpuPkg::regAddrWidth-1:0] readRegB;
    logic [cpuPkg::dataWidth-1:0] readDataA;
    logic [cpuPkg::dataWidth-1:0] readDataB;

    assign readRegA = fetchIns.rFmt.rs;
    // Stores and branches compare or store rd
    assign readRegB = cpuPkg::portBReg(fetchIns);

    regFile regs (
        .clock(clock),
        .rstN(rstN),
        .readRegA(readRegA),
        .readRegB(readRegB),
        .wb(wb),
        .readDataA(readDataA),
        .readDataB(readDataB)
    );

    // Same edge as the decode instruction register
    always_ff @(posedge clock) begin
        opA <= readDataA;
        opB <= readDataB;
    end

endmodule

// File: executeStage.sv
`timescale 1ns/1ps

module executeStage #(
    parameter int pcBits = 32
) (
    input  logic clock,
    input  logic rstN,
    input  cpuPkg::instrU decodeIns,
    input  logic [pcBits-1:0] decodePc,
    input  logic [cpuPkg::dataWidth-1:0] opA,
    input  logic [cpuPkg::dataWidth-1:0] opB,
    input  cpuPkg::wbReqT wb,
    input  logic [cpuPkg::dataWidth-1:0] dmemQ,
    output cpuPkg::redirectT redirect,
    output cpuPkg::stageTagT exTag,
    output cpuPkg::instrU exIns,
    output logic [cpuPkg::dataWidth-1:0] exStoreData
);
    logic [4:0] opcode;
    logic [4:0] aluOp;
    logic isJal;
    logic [cpuPkg::dataWidth-1:0] aluA;
    logic [cpuPkg::dataWidth-1:0] aluB;
    logic [cpuPkg::dataWidth-1:0] storeData;
    logic [cpuPkg::dataWidth-1:0] immExt;
    logic [cpuPkg::dataWidth-1:0] aluIn2;
    logic [cpuPkg::dataWidth-1:0] aluResult;
    logic [cpuPkg::dataWidth-1:0] pcPlusOne;
    logic cmpNotEqual;
    logic cmpLess;
    cpuPkg::instrU linkIns;
    cpuPkg::stageTagT nextTag;

    assign opcode = decodeIns.rFmt.opcode;
    assign isJal = opcode == cpuPkg::opJal;
    assign immExt = {{15{decodeIns.iFmt.imm[16]}}, decodeIns.iFmt.imm};
    assign aluOp = (opcode == cpuPkg::opRType) ? decodeIns.rFmt.aluOp : cpuPkg::aluAdd;
    assign aluIn2 = (opcode inside {cpuPkg::opAddi, cpuPkg::opLw, cpuPkg::opSw}) ? immExt : aluB;

    always_comb begin
        pcPlusOne = '0;
        pcPlusOne[pcBits-1:0] = decodePc + 1'b1;
    end

    bypassUnit bypass (
        .decodeIns(decodeIns), .opA(opA), .opB(opB), .exTag(exTag), .wb(wb),
        .dmemQ(dmemQ), .aluA(aluA), .aluB(aluB), .storeData(storeData)
    );

    aluUnit mainAlu (
        .a(aluA), .b(aluIn2), .aluOp(aluOp), .shamt(decodeIns.rFmt.shamt),
        .result(aluResult), .notEqual(), .lessThan()
    );

    // rd against rs for the branches
    aluUnit cmpAlu (
        .a(aluB), .b(aluA), .aluOp(cpuPkg::aluSub), .shamt(5'd0),
        .result(), .notEqual(cmpNotEqual), .lessThan(cmpLess)
    );

    always_comb begin
        redirect = '0;
        case (opcode)
            cpuPkg::opBne: begin
                redirect.taken = cmpNotEqual;
                redirect.target = pcPlusOne + immExt;
            end
            cpuPkg::opBlt: begin
                redirect.taken = cmpLess;
                redirect.target = pcPlusOne + immExt;
            end
            cpuPkg::opJ, cpuPkg::opJal: begin
                redirect.taken = 1'b1;
                redirect.target = {5'b0, decodeIns.jFmt.target};
            end
            cpuPkg::opJr: begin
                redirect.taken = 1'b1;
                redirect.target = aluB; // Forwarded rd
            end
            default: ;
        endcase
    end

    always_comb begin
        linkIns = cpuPkg::nopWord;
        linkIns.rFmt.rd = cpuPkg::linkReg; // jal becomes a plain R-type write
        nextTag.dest = isJal ? cpuPkg::linkReg : decodeIns.rFmt.rd;
        nextTag.writesReg = opcode inside {cpuPkg::opRType, cpuPkg::opAddi,
                                           cpuPkg::opLw, cpuPkg::opJal};
        nextTag.isLoad = opcode == cpuPkg::opLw;
        nextTag.value = isJal ? pcPlusOne : aluResult;
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            exTag <= '0;
            exIns <= cpuPkg::nopWord;
        end else begin
            exTag <= nextTag;
            exIns <= isJal ? linkIns : decodeIns;
        end
    end

    always_ff @(posedge clock) begin
        exStoreData <= storeData;
    end

    nopNeverJumps: assert property (@(posedge clock) disable iff (!rstN)
        decodeIns == cpuPkg::nopWord |-> !redirect.taken);

endmodule

// File: memoryStage.sv
`timescale 1ns/1ps

module memoryStage (
    input  logic clock,
    input  logic rstN,
    input  cpuPkg::instrU exIns,
    input  cpuPkg::stageTagT exTag,
    input  logic [cpuPkg::dataWidth-1:0] exStoreData,
    input  logic [cpuPkg::dataWidth-1:0] dmemQ,
    output logic [cpuPkg::dataWidth-1:0] dmemAddress,
    output logic [cpuPkg::dataWidth-1:0] dmemData,
    output logic dmemWren,
    output cpuPkg::wbReqT wb
);
    cpuPkg::stageTagT memTag;
    logic [cpuPkg::dataWidth-1:0] memLoad;
    logic storeFromLoad;

    assign dmemAddress = exTag.value;
    assign dmemWren = exIns.rFmt.opcode == cpuPkg::opSw;

    // Load just ahead of the store feeds its data
    assign storeFromLoad = memTag.isLoad && memTag.dest != '0 &&
                           memTag.dest == exIns.iFmt.rd;
    assign dmemData = storeFromLoad ? memLoad : exStoreData;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            memTag <= '0;
        end else begin
            memTag <= exTag;
        end
    end

    always_ff @(posedge clock) begin
        memLoad <= dmemQ;
    end

    always_comb begin
        wb.en = memTag.writesReg;
        wb.addr = memTag.dest;
        wb.data = memTag.isLoad ? memLoad : memTag.value;
    end

endmodule

// File: cpuTop.sv
`timescale 1ns/1ps

module cpuTop #(
    parameter int pcBits = 32
) (
    input  logic clock,
    input  logic rstN,
    output logic [cpuPkg::dataWidth-1:0] imemAddress,
    input  logic [cpuPkg::dataWidth-1:0] imemData,
    output logic [cpuPkg::dataWidth-1:0] dmemAddress,
    output logic [cpuPkg::dataWidth-1:0] dmemData,
    output logic dmemWren,
    input  logic [cpuPkg::dataWidth-1:0] dmemQ
);
    cpuPkg::redirectT redirect;
    cpuPkg::wbReqT wb;
    cpuPkg::stageTagT exTag;
    cpuPkg::instrU fetchIns;
    cpuPkg::instrU decodeIns;
    cpuPkg::instrU exIns;
    logic [pcBits-1:0] fetchPc;
    logic [pcBits-1:0] decodePc;
    logic [cpuPkg::dataWidth-1:0] opA;
    logic [cpuPkg::dataWidth-1:0] opB;
    logic [cpuPkg::dataWidth-1:0] exStoreData;

    fetchUnit #(.pcBits(pcBits)) fetch (
        .clock(clock), .rstN(rstN), .imemData(imemData), .redirect(redirect),
        .imemAddress(imemAddress), .fetchIns(fetchIns), .fetchPc(fetchPc),
        .decodeIns(decodeIns), .decodePc(decodePc)
    );

    decodeStage decode (
        .clock(clock), .rstN(rstN), .fetchIns(fetchIns), .wb(wb), .opA(opA), .opB(opB)
    );

    executeStage #(.pcBits(pcBits)) execute (
        .clock(clock), .rstN(rstN), .decodeIns(decodeIns), .decodePc(decodePc),
        .opA(opA), .opB(opB), .wb(wb), .dmemQ(dmemQ), .redirect(redirect),
        .exTag(exTag), .exIns(exIns), .exStoreData(exStoreData)
    );

    memoryStage memory (
        .clock(clock), .rstN(rstN), .exIns(exIns), .exTag(exTag),
        .exStoreData(exStoreData), .dmemQ(dmemQ), .dmemAddress(dmemAddress),
        .dmemData(dmemData), .dmemWren(dmemWren), .wb(wb)
    );

endmodule

// File: tbChecker.sv
`timescale 1ns/1ps

module tbChecker (
    input  logic clock,
    input  logic dmemWren,
    input  logic [31:0] dmemAddress,
    input  logic [31:0] dmemData,
    output int storeCount,
    output int valueErrors,
    output int extraStores
);
    string testName;
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];

    initial begin
        storeCount = 0;
        valueErrors = 0;
        extraStores = 0;
        testName = "none";
    end

    task automatic beginTest(input string name);
        testName = name;
        expAddr.delete();
        expData.delete();
        storeCount = 0;
    endtask

    task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    // Sampled mid-cycle while the write strobe is stable
    always @(negedge clock) begin
        if (dmemWren === 1'b1) begin
            if (storeCount >= expAddr.size()) begin
                extraStores++;
                $display("Unexpected store in %s: address %0d with data %h",
                         testName, dmemAddress, dmemData);
            end else begin
                if (dmemAddress !== expAddr[storeCount]) begin
                    valueErrors++;
                    $display("ERROR %s store %0d address: expected %0d, actual %0d",
                             testName, storeCount, expAddr[storeCount], dmemAddress);
                end
                if (dmemData !== expData[storeCount]) begin
                    valueErrors++;
                    $display("ERROR %s store %0d data: expected %h, actual %h",
                             testName, storeCount, expData[storeCount], dmemData);
                end
            end
            storeCount++;
        end
    end

endmodule

// File: tbCpu.sv
`timescale 1ns/1ps

module tbCpu;
    localparam int numTests = 5;
    localparam int progWords = 16;
    localparam int maxStores = 8;
    localparam int storeTimeout = 200;

    logic clock;
    logic rstN;
    logic [31:0] imemAddress;
    logic [31:0] imemData;
    logic [31:0] dmemAddress;
    logic [31:0] dmemData;
    logic [31:0] dmemQ;
    logic dmemWren;
    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:255];

    string testNames [numTests];
    logic [31:0] programs [numTests][progWords];
    logic [31:0] expAddr [numTests][maxStores];
    logic [31:0] expData [numTests][maxStores];
    int progLen [numTests];
    int expLen [numTests];
    int storeCount;
    int valueErrors;
    int extraStores;
    int timeouts;

    cpuTop #(.pcBits(32)) UUT (
        .clock(clock), .rstN(rstN), .imemAddress(imemAddress), .imemData(imemData),
        .dmemAddress(dmemAddress), .dmemData(dmemData), .dmemWren(dmemWren), .dmemQ(dmemQ)
    );

    tbChecker storeCheck (
        .clock(clock), .dmemWren(dmemWren), .dmemAddress(dmemAddress), .dmemData(dmemData),
        .storeCount(storeCount), .valueErrors(valueErrors), .extraStores(extraStores)
    );

    // Word-addressed memories with combinational reads
    assign imemData = imem[imemAddress[5:0]];
    assign dmemQ = dmem[dmemAddress[7:0]];

    always @(posedge clock) begin
        if (dmemWren) dmem[dmemAddress[7:0]] <= dmemData;
    end

    always #4 clock = ~clock;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] signExt17(input logic [31:0] v);
        return {{15{v[16]}}, v[16:0]};
    endfunction

    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return 32'h5A5A0000 + addr * 32'h01000193;
    endfunction

    function automatic logic [31:0] encR(input logic [4:0] aluOp, input int rd, input int rs,
                                         input int rt, input int shamt);
        return {cpuPkg::opRType, rd[4:0], rs[4:0], rt[4:0], shamt[4:0], aluOp, 2'b00};
    endfunction

    function automatic logic [31:0] encI(input logic [4:0] op, input int rd, input int rs,
                                         input int imm);
        return {op, rd[4:0], rs[4:0], imm[16:0]};
    endfunction

    function automatic logic [31:0] encJ(input logic [4:0] op, input int target);
        return {op, target[26:0]};
    endfunction

    task automatic addWord(input int t, input logic [31:0] w);
        programs[t][progLen[t]] = w;
        progLen[t]++;
    endtask

    task automatic addStore(input int t, input int addr, input logic [31:0] data);
        expAddr[t][expLen[t]] = addr;
        expData[t][expLen[t]] = data;
        expLen[t]++;
    endtask

    task automatic buildTable();
        logic [31:0] seed;
        logic [31:0] a;
        logic [31:0] b;
        seed = 32'd67890;
        seed = xorshift(seed);
        a = signExt17(seed);
        seed = xorshift(seed);
        b = signExt17(seed);
        for (int t = 0; t < numTests; t++) begin
            progLen[t] = 0;
            expLen[t] = 0;
        end

        testNames[0] = "alu ops";
        addWord(0, encI(cpuPkg::opAddi, 1, 0, a));
        addWord(0, encI(cpuPkg::opAddi, 2, 0, b));
        addWord(0, encR(cpuPkg::aluAdd, 3, 1, 2, 0));
        addWord(0, encI(cpuPkg::opSw, 3, 0, 16));
        addWord(0, encR(cpuPkg::aluSub, 4, 1, 2, 0));
        addWord(0, encI(cpuPkg::opSw, 4, 0, 17));
        addWord(0, encR(cpuPkg::aluAnd, 5, 1, 2, 0));
        addWord(0, encI(cpuPkg::opSw, 5, 0, 18));
        addWord(0, encR(cpuPkg::aluOr, 6, 1, 2, 0));
        addWord(0, encI(cpuPkg::opSw, 6, 0, 19));
        addWord(0, encR(cpuPkg::aluSll, 7, 1, 0, 5));
        addWord(0, encI(cpuPkg::opSw, 7, 0, 20));
        addWord(0, encR(cpuPkg::aluSra, 8, 2, 0, 3));
        addWord(0, encI(cpuPkg::opSw, 8, 0, 21));
        addWord(0, encJ(cpuPkg::opJ, 14));
        addStore(0, 16, a + b);
        addStore(0, 17, a - b);
        addStore(0, 18, a & b);
        addStore(0, 19, a | b);
        addStore(0, 20, a << 5);
        addStore(0, 21, $signed(b) >>> 3);

        testNames[1] = "bypass distance";
        addWord(1, encI(cpuPkg::opAddi, 1, 0, -5000));
        addWord(1, encI(cpuPkg::opSw, 1, 0, 32)); // From execute
        addWord(1, encI(cpuPkg::opSw, 1, 0, 33)); // From memory stage
        addWord(1, encI(cpuPkg::opSw, 1, 0, 34)); // Write-through
        addWord(1, encI(cpuPkg::opSw, 1, 0, 35));
        addWord(1, encI(cpuPkg::opAddi, 2, 0, 77));
        addWord(1, encR(cpuPkg::aluAdd, 3, 2, 0, 0));
        addWord(1, encR(cpuPkg::aluAdd, 4, 0, 2, 0));
        addWord(1, encR(cpuPkg::aluAdd, 5, 2, 0, 0));
        addWord(1, encI(cpuPkg::opSw, 3, 0, 36));
        addWord(1, encI(cpuPkg::opSw, 4, 0, 37));
        addWord(1, encI(cpuPkg::opSw, 5, 0, 38));
        addWord(1, encJ(cpuPkg::opJ, 12));
        for (int i = 32; i < 36; i++) addStore(1, i, -5000);
        for (int i = 36; i < 39; i++) addStore(1, i, 77);

        testNames[2] = "load use";
        addWord(2, encI(cpuPkg::opAddi, 1, 0, 100));
        addWord(2, encI(cpuPkg::opLw, 2, 0, 40));
        addWord(2, encR(cpuPkg::aluAdd, 3, 2, 1, 0));
        addWord(2, encI(cpuPkg::opSw, 3, 0, 48));
        addWord(2, encI(cpuPkg::opLw, 4, 0, 41));
        addWord(2, encI(cpuPkg::opSw, 4, 0, 49)); // Store right behind its load
        addWord(2, encI(cpuPkg::opLw, 5, 0, 42));
        addWord(2, encR(cpuPkg::aluAdd, 6, 1, 5, 0));
        addWord(2, encI(cpuPkg::opSw, 6, 0, 50));
        addWord(2, encJ(cpuPkg::opJ, 9));
        addStore(2, 48, fillWord(40) + 100);
        addStore(2, 49, fillWord(41));
        addStore(2, 50, fillWord(42) + 100);

        testNames[3] = "branches";
        addWord(3, encI(cpuPkg::opAddi, 1, 0, 5));
        addWord(3, encI(cpuPkg::opAddi, 2, 0, -3));
        addWord(3, encI(cpuPkg::opBne, 1, 2, 2)); // Taken to 5
        addWord(3, encI(cpuPkg::opSw, 1, 0, 60));
        addWord(3, encI(cpuPkg::opSw, 1, 0, 61));
        addWord(3, encI(cpuPkg::opBne, 1, 1, 2));
        addWord(3, encI(cpuPkg::opSw, 1, 0, 62));
        addWord(3, encI(cpuPkg::opBlt, 2, 1, 2)); // Signed -3 < 5 so taken to 10
        addWord(3, encI(cpuPkg::opSw, 2, 0, 63));
        addWord(3, encI(cpuPkg::opSw, 2, 0, 64));
        addWord(3, encI(cpuPkg::opBlt, 1, 2, 2));
        addWord(3, encI(cpuPkg::opSw, 2, 0, 65));
        addWord(3, encJ(cpuPkg::opJ, 12));
        addStore(3, 62, 5);
        addStore(3, 65, -3);

        testNames[4] = "jumps";
        addWord(4, encI(cpuPkg::opAddi, 1, 0, 9));
        addWord(4, encJ(cpuPkg::opJ, 4));
        addWord(4, encI(cpuPkg::opSw, 1, 0, 70));
        addWord(4, encI(cpuPkg::opSw, 1, 0, 71));
        addWord(4, encJ(cpuPkg::opJal, 10));
        addWord(4, encI(cpuPkg::opSw, 1, 0, 72)); // Return lands here
        addWord(4, encJ(cpuPkg::opJ, 6));
        for (int i = 7; i < 10; i++) addWord(4, encJ(cpuPkg::opJ, i));
        addWord(4, encI(cpuPkg::opSw, 31, 0, 74));
        addWord(4, encI(cpuPkg::opJr, 31, 0, 0));
        addWord(4, encI(cpuPkg::opSw, 1, 0, 75));
        addWord(4, encI(cpuPkg::opSw, 1, 0, 76));
        addStore(4, 74, 4 + 1); // Link value is the jal address plus one
        addStore(4, 72, 9);
    endtask

    task automatic runTest(input int t);
        int waited;
        @(negedge clock);
        rstN = 1'b0;
        // Unused words jump to themselves
        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < progLen[t]) ? programs[t][i] : encJ(cpuPkg::opJ, i);
        end
        for (int i = 0; i < 256; i++) dmem[i] = fillWord(i);
        storeCheck.beginTest(testNames[t]);
        for (int i = 0; i < expLen[t]; i++) begin
            storeCheck.expectStore(expAddr[t][i], expData[t][i]);
        end
        repeat (4) @(negedge clock);
        rstN = 1'b1;
        waited = 0;
        while (storeCount < expLen[t] && waited < storeTimeout) begin
            @(posedge clock);
            waited++;
        end
        if (storeCount < expLen[t]) begin
            timeouts++;
            $display("Timeout in %s: only %0d of %0d stores seen after %0d cycles",
                     testNames[t], storeCount, expLen[t], storeTimeout);
        end
        repeat (8) @(posedge clock); // Room for a stray late store
    endtask

    initial begin
        clock = 1'b0;
        rstN = 1'b0;
        timeouts = 0;
        buildTable();
        for (int t = 0; t < numTests; t++) runTest(t);
        $display("Errors: %0d wrong values, %0d extra stores, %0d timeouts",
                 valueErrors, extraStores, timeouts);
        if (valueErrors + extraStores + timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
cpuPkg.sv
aluUnit.sv
bypassUnit.sv
regFile.sv
fetchUnit.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
cpuTop.sv
tbChecker.sv
tbCpu.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tbCpu -f tb.f -Mdir obj_dir
	./obj_dir/VtbCpu > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	! grep -q ">>> FAIL" sim.log

clean:
	rm -rf obj_dir sim.log
